// ==== build.f ====
+incdir+include
src/dmaPkg.sv
src/dmaRegFile.sv
src/dmaStartTrigger.sv
src/dmaChannel.sv
src/dmaBusArbiter.sv
src/dmaTop.sv
verification/dmaTbMem.sv
verification/dmaTb.sv

// ==== Makefile ====
SOURCES := $(shell grep '\.sv$$' build.f)

obj_dir/VdmaTb: build.f $(SOURCES) $(wildcard include/*.svh)
	verilator --binary --timing --assert --top-module dmaTb -f build.f

run: obj_dir/VdmaTb
	./obj_dir/VdmaTb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== verification/dmaTb.sv ====
// DMA controller testbench; programs channels over APB and checks memory against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "dmaRegMap.svh"

module dmaTb
  import dmaPkg::*;
();

  localparam int NumChannels = 4;
  localparam int MemBytes    = 4096;
  localparam int Timeout     = 4000;  // cycles

  logic        clk;
  logic        rst_b;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [15:0] hcount;
  logic [15:0] vcount;
  memReqT      memReq;
  memRspT      memRsp;
  logic        irq;
  logic        stallOn;
  logic        fillEn;
  logic [7:0]  model [MemBytes];  // expected memory image
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  int          irqCount;

  dmaTop #(.NumChannels(NumChannels)) dut_i (
    .clk, .rst_b, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .hcount, .vcount, .memReq, .memRsp, .irq
  );

  dmaTbMem #(.MemBytes(MemBytes)) mem_i (
    .clk, .rst_b, .stallOn, .fillEn, .memReq, .memRsp
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst_b) irqCount <= 0;
    else if (irq) irqCount <= irqCount + 1;
  end

  // expected copy; updates the model image and queues the write beats in order
  function automatic void refCopy(input logic [31:0] src, input logic [31:0] dst, input int count,
                                  input addrModeT srcMode, input addrModeT dstMode,
                                  input logic word, output logic [31:0] srcEnd,
                                  output logic [31:0] dstEnd);
    int          beats;
    int          width;
    logic [31:0] step;
    logic [31:0] s;
    logic [31:0] d;
    logic [31:0] v;
    beats = (count == 0) ? 16384 : count;
    width = word ? 4 : 2;
    step  = word ? 32'd4 : 32'd2;
    s     = src;
    d     = dst;
    for (int k = 0; k < beats; k++) begin
      v = '0;
      for (int b = 0; b < width; b++) v[8*b +: 8] = model[int'(s[11:0]) + b];
      for (int b = 0; b < width; b++) model[int'(d[11:0]) + b] = v[8*b +: 8];
      expAddr.push_back(d);
      expData.push_back(v);
      if (srcMode == AddrDec) s = s - step;
      else if (srcMode != AddrFixed) s = s + step;
      if (dstMode == AddrDec) d = d - step;
      else if (dstMode != AddrFixed) d = d + step;
    end
    srcEnd = s;
    dstEnd = (dstMode == AddrReload) ? dst : d;  // a repeat starts over at the register value
  endfunction

  function automatic logic [31:0] regAddr(input int ch, input logic [31:0] ofs);
    return 32'(ch) * `DmaChanStride + ofs;
  endfunction

  function automatic logic [31:0] ctrlWord(input startModeT start, input addrModeT srcMode,
                                           input addrModeT dstMode, input logic word,
                                           input logic rpt, input logic irqOn);
    return {16'd0, 1'b1, irqOn, start, 1'b0, word, rpt, srcMode, dstMode, 5'd0};
  endfunction

  task automatic checkEq(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "a checked value was wrong");
    end
  endtask

  task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    paddr  = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel   = 1'b1;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apbRead(input logic [31:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    paddr  = addr;
    pwrite = 1'b0;
    psel   = 1'b1;
    @(negedge clk);
    penable = 1'b1;
    #10;  // mid access phase
    checkEq("apb pready", 32'd1, {31'd0, pready});
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic loadChannel(input int ch, input logic [31:0] src, input logic [31:0] dst,
                             input logic [31:0] count);
    apbWrite(regAddr(ch, `DmaSrcAddrOfs), src);
    apbWrite(regAddr(ch, `DmaDstAddrOfs), dst);
    apbWrite(regAddr(ch, `DmaCountOfs), count);
  endtask

  task automatic checkCtrl(input string name, input int ch, input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    apbRead(regAddr(ch, `DmaCtrlOfs), data, err);
    checkEq(name, expected, data);
  endtask

  task automatic waitWrites(input string name, input int total);
    int cycles;
    cycles = 0;
    while (mem_i.logAddr.size() < total) begin
      if (cycles == Timeout) begin
        $display("SOME TESTS FAILED");
        $fatal(1, "timed out in %s waiting for DMA write beats", name);
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic clearExpected();
    expAddr.delete();
    expData.delete();
  endtask

  // compares the logged writes inside [lo, hi) with the expected beats in the same range
  task automatic checkWrites(input string name, input int first, input logic [31:0] lo,
                             input logic [31:0] hi);
    logic [31:0] gotA [$];
    logic [31:0] gotD [$];
    logic [31:0] wantA [$];
    logic [31:0] wantD [$];
    for (int i = first; i < mem_i.logAddr.size(); i++) begin
      if (mem_i.logAddr[i] >= lo && mem_i.logAddr[i] < hi) begin
        gotA.push_back(mem_i.logAddr[i]);
        gotD.push_back(mem_i.logData[i]);
      end
    end
    for (int i = 0; i < expAddr.size(); i++) begin
      if (expAddr[i] >= lo && expAddr[i] < hi) begin
        wantA.push_back(expAddr[i]);
        wantD.push_back(expData[i]);
      end
    end
    checkEq({name, " beat count"}, wantA.size(), gotA.size());
    for (int i = 0; i < wantA.size(); i++) begin
      checkEq($sformatf("%s beat %0d addr", name, i), wantA[i], gotA[i]);
      checkEq($sformatf("%s beat %0d data", name, i), wantD[i], gotD[i]);
    end
  endtask

  task automatic checkMem(input string name);
    for (int i = 0; i < MemBytes; i++) begin
      if (mem_i.store[i] !== model[i]) begin
        checkEq($sformatf("%s mem[%0h]", name, i), 32'(model[i]), 32'(mem_i.store[i]));
      end
    end
  endtask

  task automatic fillMemory();
    @(negedge clk);
    fillEn = 1'b1;
    @(negedge clk);
    fillEn = 1'b0;
    for (int i = 0; i < MemBytes; i++) model[i] = mem_i.store[i];
  endtask

  task automatic checkResetValues();
    logic [31:0] ofs [4] = '{`DmaSrcAddrOfs, `DmaDstAddrOfs, `DmaCountOfs, `DmaCtrlOfs};
    logic [31:0] data;
    logic        err;
    for (int ch = 0; ch < NumChannels; ch++) begin
      for (int r = 0; r < 4; r++) begin
        apbRead(regAddr(ch, ofs[r]), data, err);
        checkEq($sformatf("reset ch%0d reg%0d", ch, r), 32'd0, data);
        checkEq($sformatf("reset ch%0d reg%0d pslverr", ch, r), 32'd0, {31'd0, err});
      end
    end
    apbRead(regAddr(NumChannels, `DmaSrcAddrOfs), data, err);
    checkEq("beyond map pslverr", 32'd1, {31'd0, err});
  endtask

  task automatic testWordCopy(input string tag);
    logic [31:0] s;
    logic [31:0] d;
    logic [31:0] ctrl;
    int          first;
    int          irqBase;
    first   = mem_i.logAddr.size();
    irqBase = irqCount;
    clearExpected();
    ctrl = ctrlWord(StartImmediate, AddrInc, AddrInc, 1'b1, 1'b0, 1'b1);
    refCopy(32'h100, 32'h400, 8, AddrInc, AddrInc, 1'b1, s, d);
    loadChannel(0, 32'h100, 32'h400, 32'd8);
    apbWrite(regAddr(0, `DmaCtrlOfs), ctrl);
    waitWrites({tag, " word copy"}, first + 8);
    checkWrites({tag, " word copy"}, first, 32'h400, 32'h420);
    checkMem({tag, " word copy"});
    checkCtrl({tag, " word copy ctrl"}, 0, ctrl & ~32'h8000);  // enable cleared on done
    checkEq({tag, " word copy irq pulses"}, 32'(irqBase + 1), 32'(irqCount));
  endtask

  task automatic testHalfDecFixed(input string tag);
    logic [31:0] s;
    logic [31:0] d;
    int          first;
    int          irqBase;
    first   = mem_i.logAddr.size();
    irqBase = irqCount;
    clearExpected();
    refCopy(32'h21E, 32'h500, 6, AddrDec, AddrFixed, 1'b0, s, d);
    loadChannel(1, 32'h21E, 32'h500, 32'd6);
    apbWrite(regAddr(1, `DmaCtrlOfs), ctrlWord(StartImmediate, AddrDec, AddrFixed, 1'b0, 1'b0, 1'b0));
    waitWrites({tag, " halfword copy"}, first + 6);
    checkWrites({tag, " halfword copy"}, first, 32'h500, 32'h502);
    checkMem({tag, " halfword copy"});
    checkEq({tag, " halfword copy no irq"}, 32'(irqBase), 32'(irqCount));
  endtask

  task automatic testVblankRepeat(input string tag);
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] ctrl;
    int          first;
    src  = 32'h300;
    dst  = 32'h600;
    ctrl = ctrlWord(StartVblank, AddrInc, AddrReload, 1'b1, 1'b1, 1'b0);
    first = mem_i.logAddr.size();
    loadChannel(1, src, dst, 32'd4);
    apbWrite(regAddr(1, `DmaCtrlOfs), ctrl);
    repeat (20) @(negedge clk);
    checkEq({tag, " vblank idle writes"}, 32'(first), 32'(mem_i.logAddr.size()));
    for (int blk = 0; blk < 2; blk++) begin
      first = mem_i.logAddr.size();
      clearExpected();
      refCopy(src, dst, 4, AddrInc, AddrReload, 1'b1, src, dst);  // source carries on
      @(negedge clk);
      vcount = VblankCount;
      repeat (3) @(negedge clk);
      vcount = 16'd0;
      waitWrites({tag, " vblank block"}, first + 4);
      repeat (10) @(negedge clk);
      checkWrites($sformatf("%s vblank block %0d", tag, blk), first, 32'h600, 32'h610);
      checkMem({tag, " vblank block"});
      checkCtrl({tag, " vblank ctrl"}, 1, ctrl);  // enable stays set on repeat
    end
    apbWrite(regAddr(1, `DmaCtrlOfs), 32'd0);
  endtask

  task automatic testPriority(input string tag);
    logic [31:0] s;
    logic [31:0] d;
    int          first;
    int          ch0First;
    int          ch0Last;
    int          ch2Last;
    int          ch2Between;
    first = mem_i.logAddr.size();
    clearExpected();
    refCopy(32'h700, 32'h900, 16, AddrInc, AddrInc, 1'b1, s, d);
    refCopy(32'h800, 32'hA00, 4, AddrInc, AddrInc, 1'b1, s, d);
    loadChannel(2, 32'h700, 32'h900, 32'd16);
    loadChannel(0, 32'h800, 32'hA00, 32'd4);
    apbWrite(regAddr(2, `DmaCtrlOfs), ctrlWord(StartImmediate, AddrInc, AddrInc, 1'b1, 1'b0, 1'b0));
    apbWrite(regAddr(0, `DmaCtrlOfs), ctrlWord(StartImmediate, AddrInc, AddrInc, 1'b1, 1'b0, 1'b0));
    waitWrites({tag, " priority"}, first + 20);
    ch0First   = -1;
    ch0Last    = -1;
    ch2Last    = -1;
    ch2Between = 0;
    for (int i = first; i < mem_i.logAddr.size(); i++) begin
      if (mem_i.logAddr[i] >= 32'hA00 && mem_i.logAddr[i] < 32'hA10) begin
        if (ch0First < 0) ch0First = i;
        ch0Last = i;
      end else begin
        ch2Last = i;
      end
    end
    for (int i = ch0First; i <= ch0Last; i++) begin
      if (mem_i.logAddr[i] >= 32'h900 && mem_i.logAddr[i] < 32'h940) ch2Between++;
    end
    checkEq({tag, " ch2 beats inside ch0 run"}, 32'd0, 32'(ch2Between));
    checkEq({tag, " ch0 done before ch2"}, 32'd1, {31'd0, ch0Last < ch2Last});
    checkWrites({tag, " priority ch0"}, first, 32'hA00, 32'hA10);
    checkWrites({tag, " priority ch2"}, first, 32'h900, 32'h940);
    checkMem({tag, " priority"});
  endtask

  task automatic runSuite(input string tag, input logic stalls);
    stallOn = stalls;
    fillMemory();
    testWordCopy(tag);
    testHalfDecFixed(tag);
    testVblankRepeat(tag);
    testPriority(tag);
  endtask

  initial begin
    void'($urandom(56366));
    rst_b   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    hcount  = '0;
    vcount  = '0;
    stallOn = 1'b0;
    fillEn  = 1'b0;
    repeat (8) @(negedge clk);
    rst_b = 1'b1;
    checkResetValues();
    runSuite("ready", 1'b0);
    runSuite("stalled", 1'b1);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/dmaTbMem.sv ====
// byte memory model for the DMA testbench; random fill, random ready stalls and a log of write beats
`timescale 1ns/1ps
`default_nettype none

module dmaTbMem
  import dmaPkg::*;
#(
  parameter int MemBytes = 4096
) (
  input  logic   clk,
  input  logic   rst_b,
  input  logic   stallOn,
  input  logic   fillEn,
  input  memReqT memReq,
  output memRspT memRsp
);

  localparam int AddrW = $clog2(MemBytes);

  logic [7:0]  store [MemBytes];
  logic [31:0] logAddr [$];
  logic [31:0] logData [$];  // halfword beats logged zero extended
  logic        ready;

  always_comb begin
    memRsp.ready = ready;
    for (int i = 0; i < 4; i++) begin
      memRsp.rdata[8*i +: 8] = store[AddrW'(memReq.addr + 32'(i))];  // little endian
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      ready <= 1'b0;
    end else begin
      ready <= !stallOn || ($urandom % 4 != 0);  // stall about one cycle in four
    end
  end

  always @(posedge clk) begin
    if (fillEn) begin
      for (int i = 0; i < MemBytes; i++) begin
        store[i] = 8'($urandom);
      end
    end else if (memReq.valid && ready && memReq.write) begin
      for (int i = 0; i < 4; i++) begin
        if (memReq.wordSize || i < 2) store[AddrW'(memReq.addr + 32'(i))] = memReq.wdata[8*i +: 8];
      end
      logAddr.push_back(memReq.addr);
      logData.push_back(memReq.wordSize ? memReq.wdata : {16'd0, memReq.wdata[15:0]});
    end
  end

endmodule

`default_nettype wire

// ==== src/dmaTop.sv ====
// DMA controller top level; APB programming port, display counters in, one memory master out
`timescale 1ns/1ps
`default_nettype none

module dmaTop
  import dmaPkg::*;
#(
  parameter int NumChannels = 4
) (
  input  logic        clk,
  input  logic        rst_b,
  input  logic [31:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic [15:0] hcount,
  input  logic [15:0] vcount,
  output memReqT      memReq,
  input  memRspT      memRsp,
  output logic        irq
);

  dmaChanRegsT            chanRegs [NumChannels];
  dmaCtrlT                chanCtrl [NumChannels];
  memReqT                 chanReq [NumChannels];
  memRspT                 chanRsp [NumChannels];
  logic [NumChannels-1:0] chanDone;
  logic [NumChannels-1:0] chanStart;
  logic [NumChannels-1:0] chanIrq;
  logic [NumChannels-1:0] grant;

  assign irq = |chanIrq;

  dmaRegFile #(.NumChannels(NumChannels)) regFile_i (
    .clk, .rst_b, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .chanDone, .chanRegs, .chanCtrl
  );

  for (genvar i = 0; i < NumChannels; i++) begin : gChan
    dmaStartTrigger trigger_i (
      .clk, .rst_b, .ctrl(chanCtrl[i]), .hcount, .vcount, .start(chanStart[i])
    );

    dmaChannel channel_i (
      .clk, .rst_b, .regs(chanRegs[i]), .ctrl(chanCtrl[i]), .start(chanStart[i]),
      .grant(grant[i]), .memRsp(chanRsp[i]), .memReq(chanReq[i]),
      .irq(chanIrq[i]), .done(chanDone[i])
    );
  end

  dmaBusArbiter #(.NumChannels(NumChannels)) arbiter_i (
    .clk, .rst_b, .chanReq, .memRsp, .grant, .memReq, .chanRsp
  );

endmodule

`default_nettype wire

// ==== src/dmaBusArbiter.sv ====
// fixed-priority owner of the shared memory port; channel 0 wins whenever the bus is idle
`timescale 1ns/1ps
`default_nettype none

module dmaBusArbiter
  import dmaPkg::*;
#(
  parameter int NumChannels = 4
) (
  input  logic                   clk,
  input  logic                   rst_b,
  input  memReqT                 chanReq [NumChannels],
  input  memRspT                 memRsp,
  output logic [NumChannels-1:0] grant,
  output memReqT                 memReq,
  output memRspT                 chanRsp [NumChannels]
);

  localparam int ChanW = (NumChannels > 1) ? $clog2(NumChannels) : 1;

  logic [ChanW-1:0] ownerQ;
  logic             busyQ;  // owner's beat is stalled on the bus
  logic [ChanW-1:0] pick;
  logic             anyReq;
  logic [ChanW-1:0] owner;

  always_comb begin
    pick   = '0;
    anyReq = 1'b0;
    for (int i = NumChannels - 1; i >= 0; i--) begin
      if (chanReq[i].valid) begin
        pick   = ChanW'(i);
        anyReq = 1'b1;
      end
    end
  end

  assign owner = busyQ ? ownerQ : pick;

  always_comb begin
    grant = '0;
    if (busyQ || anyReq) grant[owner] = 1'b1;
  end

  assign memReq = (busyQ || anyReq) ? chanReq[owner] : '0;

  for (genvar i = 0; i < NumChannels; i++) begin : gRsp
    assign chanRsp[i] = '{ready: grant[i] && memRsp.ready, rdata: memRsp.rdata};
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      ownerQ <= '0;
      busyQ  <= 1'b0;
    end else begin
      busyQ <= memReq.valid && !memRsp.ready;
      if (!busyQ) ownerQ <= pick;
    end
  end

  // the owner keeps its request up while it holds the bus
  assert property (@(posedge clk) disable iff (!rst_b) |grant |-> memReq.valid);

  // no handover in the middle of a stalled beat
  assert property (@(posedge clk) disable iff (!rst_b)
    memReq.valid && !memRsp.ready |=> $stable(grant));

endmodule

`default_nettype wire

// ==== src/dmaChannel.sv ====
// one DMA channel engine; copies a block one read beat then one write beat at a time
`timescale 1ns/1ps
`default_nettype none

module dmaChannel
  import dmaPkg::*;
(
  input  logic        clk,
  input  logic        rst_b,
  input  dmaChanRegsT regs,
  input  dmaCtrlT     ctrl,
  input  logic        start,
  input  logic        grant,
  input  memRspT      memRsp,
  output memReqT      memReq,
  output logic        irq,
  output logic        done
);

  typedef enum logic [2:0] {OFF, IDLE, QUEUED, READ, WRITE} stateT;

  stateT       state;
  stateT       stateNext;
  logic        oweWrite;  // preempted after the read beat
  logic [31:0] srcAddr;
  logic [31:0] dstAddr;
  logic [14:0] beatsLeft;
  logic [31:0] data;
  logic        wordSizeQ;
  logic [14:0] fullCount;
  logic [31:0] step;
  logic        pending;
  logic        isWrite;
  logic        fire;
  logic        lastWrite;

  function automatic logic [31:0] stepAddr(input logic [31:0] addr, input addrModeT mode,
                                           input logic [31:0] delta);
    case (mode)
      AddrDec:   return addr - delta;
      AddrFixed: return addr;
      default:   return addr + delta;  // reload also counts up within a block
    endcase
  endfunction

  assign fullCount = (regs.count == '0) ? 15'd16384 : {1'b0, regs.count};
  assign step      = wordSizeQ ? 32'd4 : 32'd2;
  assign pending   = state == QUEUED || state == READ || state == WRITE;
  assign isWrite   = state == WRITE || (state == QUEUED && oweWrite);
  assign fire      = pending && grant && memRsp.ready;
  assign lastWrite = fire && isWrite && beatsLeft == 15'd1;
  assign done      = lastWrite && !ctrl.repeatEn;
  assign irq       = lastWrite && ctrl.irqEn;

  assign memReq = '{valid: pending, write: isWrite, wordSize: wordSizeQ,
                    addr: isWrite ? dstAddr : srcAddr, wdata: data};

  always_comb begin
    stateNext = state;
    case (state)
      OFF: if (ctrl.enable) stateNext = IDLE;
      IDLE: begin
        if (!ctrl.enable) stateNext = OFF;
        else if (start) stateNext = QUEUED;
      end
      default: begin
        if (!grant) stateNext = ctrl.enable ? QUEUED : OFF;  // wait out a higher channel
        else if (!fire) stateNext = isWrite ? WRITE : READ;  // stalled beat holds
        else if (!isWrite) stateNext = WRITE;
        else if (beatsLeft != 15'd1) stateNext = READ;
        else stateNext = ctrl.repeatEn ? IDLE : OFF;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state    <= OFF;
      oweWrite <= 1'b0;
    end else begin
      state <= stateNext;
      if (state == IDLE) oweWrite <= 1'b0;
      else if (pending && !grant) oweWrite <= isWrite;
    end
  end

  always_ff @(posedge clk) begin
    if (state == OFF && ctrl.enable) begin
      srcAddr   <= regs.srcAddr;
      dstAddr   <= regs.dstAddr;
      beatsLeft <= fullCount;
      wordSizeQ <= ctrl.wordSize;
    end else if (fire && !isWrite) begin
      data    <= memRsp.rdata;
      srcAddr <= stepAddr(srcAddr, ctrl.srcMode, step);
    end else if (fire && !lastWrite) begin
      beatsLeft <= beatsLeft - 15'd1;
      dstAddr   <= stepAddr(dstAddr, ctrl.dstMode, step);
    end else if (lastWrite) begin
      beatsLeft <= fullCount;  // rearm for a repeat
      if (ctrl.dstMode == AddrReload) begin
        dstAddr <= regs.dstAddr;
      end else begin
        dstAddr <= stepAddr(dstAddr, ctrl.dstMode, step);
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_b)
    memReq.valid && grant && !memRsp.ready |=> $stable(memReq));

endmodule

`default_nettype wire

// ==== src/dmaStartTrigger.sv ====
// start pulse generator for one DMA channel, driven by its timing mode and the display counters
`timescale 1ns/1ps
`default_nettype none

module dmaStartTrigger
  import dmaPkg::*;
(
  input  logic        clk,
  input  logic        rst_b,
  input  dmaCtrlT     ctrl,
  input  logic [15:0] hcount,
  input  logic [15:0] vcount,
  output logic        start
);

  logic match;
  logic matchQ;  // counter already sat on its compare value

  always_comb begin
    case (ctrl.startMode)
      StartHblank:                   match = hcount == HblankCount;
      StartVblank:                   match = vcount == VblankCount;
      StartImmediate, StartReserved: match = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      matchQ <= 1'b0;
    end else begin
      matchQ <= match;
    end
  end

  // immediate mode keeps asking while enabled
  assign start = ctrl.enable && (ctrl.startMode == StartImmediate || (match && !matchQ));

endmodule

`default_nettype wire

// ==== src/dmaRegFile.sv ====
// APB register file holding every DMA channel's programming, with enable cleared on completion
`timescale 1ns/1ps
`default_nettype none

`include "dmaRegMap.svh"

module dmaRegFile
  import dmaPkg::*;
#(
  parameter int NumChannels = 4
) (
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic [31:0]            paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic [NumChannels-1:0] chanDone,
  output dmaChanRegsT            chanRegs [NumChannels],
  output dmaCtrlT                chanCtrl [NumChannels]
);

  localparam int ChanW = (NumChannels > 1) ? $clog2(NumChannels) : 1;

  logic [31:0]            srcQ [NumChannels];
  logic [31:0]            dstQ [NumChannels];
  logic [13:0]            countQ [NumChannels];
  dmaCtrlT                ctrlQ [NumChannels];
  logic [31:0]            chanIdx;
  logic [31:0]            regOfs;
  logic [ChanW-1:0]       chanSel;
  logic                   inRange;
  logic [NumChannels-1:0] chanWr;
  logic [NumChannels-1:0] ctrlWr;

  assign chanIdx = paddr / `DmaChanStride;
  assign regOfs  = paddr % `DmaChanStride;
  assign chanSel = chanIdx[ChanW-1:0];
  assign inRange = chanIdx < NumChannels;
  assign pready  = 1'b1;  // every access completes in its access phase
  assign pslverr = psel && penable && !inRange;

  always_comb begin
    for (int i = 0; i < NumChannels; i++) begin
      chanWr[i] = psel && penable && pwrite && chanIdx == i;
      ctrlWr[i] = chanWr[i] && regOfs == `DmaCtrlOfs;
    end
  end

  always_comb begin
    prdata = '0;
    if (inRange) begin
      case (regOfs)
        `DmaSrcAddrOfs: prdata = srcQ[chanSel];
        `DmaDstAddrOfs: prdata = dstQ[chanSel];
        `DmaCountOfs:   prdata = {18'd0, countQ[chanSel]};
        `DmaCtrlOfs:    prdata = {16'd0, ctrlQ[chanSel]};
        default:        prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int i = 0; i < NumChannels; i++) begin
        srcQ[i]   <= '0;
        dstQ[i]   <= '0;
        countQ[i] <= '0;
        ctrlQ[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < NumChannels; i++) begin
        if (chanWr[i] && regOfs == `DmaSrcAddrOfs) srcQ[i] <= pwdata;
        if (chanWr[i] && regOfs == `DmaDstAddrOfs) dstQ[i] <= pwdata;
        if (chanWr[i] && regOfs == `DmaCountOfs) countQ[i] <= pwdata[13:0];
        if (ctrlWr[i]) ctrlQ[i] <= dmaCtrlT'(pwdata[15:0]);
        else if (chanDone[i]) ctrlQ[i].enable <= 1'b0;  // channel stopped on its own
      end
    end
  end

  for (genvar i = 0; i < NumChannels; i++) begin : gChan
    assign chanRegs[i] = '{srcAddr: srcQ[i], dstAddr: dstQ[i], pad: 2'b00, count: countQ[i]};
    assign chanCtrl[i] = ctrlQ[i];

    // a repeating channel rearms and never reports done
    assert property (@(posedge clk) disable iff (!rst_b)
      chanDone[i] |-> !chanCtrl[i].repeatEn);
  end

endmodule

`default_nettype wire

// ==== src/dmaPkg.sv ====
// shared DMA types and constants, pulled into each module by a wildcard import
`default_nettype none

package dmaPkg;

  localparam logic [15:0] HblankCount = 16'd240;  // hcount at horizontal blank
  localparam logic [15:0] VblankCount = 16'd160;  // vcount at vertical blank

  typedef enum logic [1:0] {
    AddrInc    = 2'd0,
    AddrDec    = 2'd1,
    AddrFixed  = 2'd2,
    AddrReload = 2'd3  // destination only
  } addrModeT;

  typedef enum logic [1:0] {
    StartImmediate = 2'd0,
    StartHblank    = 2'd1,
    StartVblank    = 2'd2,
    StartReserved  = 2'd3
  } startModeT;

  typedef struct packed {
    logic       enable;     // bit 15
    logic       irqEn;
    startModeT  startMode;  // 13:12
    logic       rsvd11;
    logic       wordSize;   // 1 selects 32-bit beats
    logic       repeatEn;
    addrModeT   srcMode;    // 8:7
    addrModeT   dstMode;    // 6:5
    logic [4:0] rsvdLow;
  } dmaCtrlT;

  typedef struct packed {
    logic [31:0] srcAddr;
    logic [31:0] dstAddr;
    logic [1:0]  pad;
    logic [13:0] count;  // 0 stands for 16384
  } dmaChanRegsT;

  // Halfword beats carry their data in the low 16 bits of wdata and rdata.
  typedef struct packed {
    logic        valid;
    logic        write;
    logic        wordSize;
    logic [31:0] addr;
    logic [31:0] wdata;
  } memReqT;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } memRspT;

endpackage

`default_nettype wire

// ==== include/dmaRegMap.svh ====
// APB byte offsets of the DMA channel registers, included wherever the map is decoded or driven
`ifndef dmaRegMapSvh
`define dmaRegMapSvh

// offsets inside one channel block
`define DmaSrcAddrOfs 32'h0
`define DmaDstAddrOfs 32'h4
`define DmaCountOfs   32'h8
`define DmaCtrlOfs    32'hC

// channel n begins at n times the stride
`define DmaChanStride 32'h10

`endif
